// File: design/alu.sv
// Integer ALU with address computation and branch condition
`timescale 1ns/1ps
`default_nettype none

module alu
   import mimic_pkg::*;
(
   input  opcode_t opcode,
   input  word_t   rs,
   input  word_t   rt,
   input  word_t   imm,
   output word_t   result,
   output logic    branch_taken
);

   logic less_than;

   assign less_than = $signed(rs) < $signed(rt);

   always_comb begin
      case (opcode)
         OP_ADD:  result = rs + rt;
         OP_SUB:  result = rs - rt;
         OP_AND:  result = rs & rt;
         OP_OR:   result = rs | rt;
         OP_SLT:  result = {{(WORD_WIDTH-1){1'b0}}, less_than};
         // Immediate add and memory address share the adder
         OP_ADDI,
         OP_LW,
         OP_SW:   result = rs + imm;
         default: result = '0;
      endcase
   end

   always_comb begin
      case (opcode)
         OP_BEQ:  branch_taken = (rs == rt);
         OP_BNE:  branch_taken = (rs != rt);
         default: branch_taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/decoder.sv
// Instruction decoder that registers opcode, register addresses and sign-extended immediate
`timescale 1ns/1ps
`default_nettype none

module decoder
   import mimic_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      load,
   input  word_t     inst,
   output opcode_t   opcode,
   output reg_addr_t rs_addr,
   output reg_addr_t rt_addr,
   output reg_addr_t rd_addr,
   output word_t     imm
);

   logic [IMM_WIDTH-1:0] raw_imm;

   assign raw_imm = inst[IMM_MSB:IMM_LSB];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         opcode  <= OP_ADD;
         rs_addr <= '0;
         rt_addr <= '0;
         rd_addr <= '0;
      end else if (load) begin
         opcode  <= opcode_t'(inst[OPCODE_MSB:OPCODE_LSB]);
         rs_addr <= inst[RS_MSB:RS_LSB];
         rt_addr <= inst[RT_MSB:RT_LSB];
         rd_addr <= inst[RD_MSB:RD_LSB];
      end
   end

   // Sign-extended immediate
   always_ff @(posedge clk) begin
      if (load) begin
         imm <= {{(WORD_WIDTH-IMM_WIDTH){raw_imm[IMM_WIDTH-1]}}, raw_imm};
      end
   end

endmodule

`default_nettype wire

// File: design/instruction_loader.sv
// Packs received bytes big-endian into words and fills the instruction memory
`timescale 1ns/1ps
`default_nettype none

module instruction_loader
   import mimic_pkg::*;
#(
   parameter int IMEM_ADDR_WIDTH = 10
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       rx_waiting,
   input  byte_t                      received_data,
   output logic                       pop,
   output logic                       write_enable,
   output logic [IMEM_ADDR_WIDTH-1:0] write_address,
   output word_t                      write_data,
   output logic                       in_execution
);

   logic [1:0]                 byte_count;
   logic [3*BYTE_WIDTH-1:0]    partial;
   logic [IMEM_ADDR_WIDTH-1:0] next_address;
   word_t                      assembled;
   logic                       word_done;

   // One byte per cycle while the FIFO has data
   assign pop       = !rx_waiting && !in_execution;
   assign assembled = {partial, received_data};
   assign word_done = pop && (byte_count == 2'd3);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         byte_count    <= '0;
         next_address  <= '0;
         write_address <= '0;
         write_enable  <= 1'b0;
         in_execution  <= 1'b0;
      end else begin
         write_enable <= 1'b0;
         if (pop) begin
            byte_count <= byte_count + 2'd1;
         end
         if (word_done) begin
            if (assembled == LOAD_END_WORD) begin
               in_execution <= 1'b1;
            end else begin
               write_enable  <= 1'b1;
               write_address <= next_address;
               next_address  <= next_address + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         partial <= {partial[2*BYTE_WIDTH-1:0], received_data};
      end
      if (word_done) begin
         write_data <= assembled;
      end
   end

endmodule

`default_nettype wire

// File: design/instruction_memory.sv
// Single-port instruction RAM with registered read
`timescale 1ns/1ps
`default_nettype none

module instruction_memory
   import mimic_pkg::*;
#(
   parameter int IMEM_ADDR_WIDTH = 10
) (
   input  logic                       clk,
   input  logic                       write_enable,
   input  logic [IMEM_ADDR_WIDTH-1:0] address,
   input  word_t                      write_data,
   output word_t                      read_data
);

   word_t mem [2**IMEM_ADDR_WIDTH];

   always_ff @(posedge clk) begin
      if (write_enable) begin
         mem[address] <= write_data;
      end
      read_data <= mem[address];
   end

endmodule

`default_nettype wire

// File: design/mimic.sv
// mimic top level, serial program loader and multi-cycle integer core
`timescale 1ns/1ps
`default_nettype none

module mimic
   import mimic_pkg::*;
#(
   parameter int IMEM_ADDR_WIDTH = 10
) (
   input  logic  clk,
   input  logic  arst_n,

   output logic  mem_write_enable,
   output word_t mem_addr,
   output word_t mem_write_data,
   input  word_t mem_read_data,

   output logic  tx_send_enable,
   output byte_t tx_send_data,

   input  byte_t rx_received_data,
   input  logic  rx_waiting,
   output logic  rx_fifo_pop,

   output logic  halted
);

   logic [IMEM_ADDR_WIDTH-1:0] inst_address;
   logic [IMEM_ADDR_WIDTH-1:0] inst_write_address;
   logic [IMEM_ADDR_WIDTH-1:0] pc;
   word_t                      inst_write_data;
   word_t                      inst_fetch;
   logic                       inst_write_enable;
   logic                       in_execution;
   logic                       loader_pop;
   logic                       cpu_rx_pop;

   opcode_t   opcode;
   reg_addr_t rs_addr, rt_addr, rd_addr;
   word_t     imm;
   logic      decode_load;
   word_t     rs_data, rt_data;
   word_t     alu_result;
   logic      branch_taken;
   logic      reg_write_enable;
   reg_addr_t reg_write_addr;
   word_t     reg_write_data;

   assign rx_fifo_pop  = loader_pop | cpu_rx_pop;
   assign inst_address = in_execution ? pc : inst_write_address;

   // ##################################################
   // Loading
   instruction_loader #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) instruction_loader_inst (
      .clk(clk), .arst_n(arst_n),
      .rx_waiting(rx_waiting), .received_data(rx_received_data), .pop(loader_pop),
      .write_enable(inst_write_enable), .write_address(inst_write_address),
      .write_data(inst_write_data), .in_execution(in_execution));

   instruction_memory #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) instruction_memory_inst (
      .clk(clk), .write_enable(inst_write_enable), .address(inst_address),
      .write_data(inst_write_data), .read_data(inst_fetch));

   // ##################################################
   // Decode, register read, execute
   decoder decoder_inst (
      .clk(clk), .arst_n(arst_n), .load(decode_load), .inst(inst_fetch),
      .opcode(opcode), .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(rd_addr), .imm(imm));

   register_file register_file_inst (
      .clk(clk), .arst_n(arst_n),
      .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
      .write_enable(reg_write_enable), .write_addr(reg_write_addr),
      .write_data(reg_write_data));

   alu alu_inst (
      .opcode(opcode), .rs(rs_data), .rt(rt_data), .imm(imm),
      .result(alu_result), .branch_taken(branch_taken));

   sequencer #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) sequencer_inst (
      .clk(clk), .arst_n(arst_n), .in_execution(in_execution),
      .opcode(opcode), .rt_addr(rt_addr), .rd_addr(rd_addr), .imm(imm),
      .alu_result(alu_result), .rt_data(rt_data), .mem_read_data(mem_read_data),
      .branch_taken(branch_taken), .rx_waiting(rx_waiting),
      .rx_received_data(rx_received_data), .pc(pc), .decode_load(decode_load),
      .reg_write_enable(reg_write_enable), .reg_write_addr(reg_write_addr),
      .reg_write_data(reg_write_data), .mem_write_enable(mem_write_enable),
      .mem_addr(mem_addr), .mem_write_data(mem_write_data),
      .tx_send_enable(tx_send_enable), .tx_send_data(tx_send_data),
      .rx_pop(cpu_rx_pop), .halted(halted));

endmodule

`default_nettype wire

// File: design/mimic_pkg.sv
// mimic shared types, instruction field positions, opcodes and the load end marker
`default_nettype none

package mimic_pkg;

   localparam int WORD_WIDTH     = 32;
   localparam int BYTE_WIDTH     = 8;
   localparam int REG_ADDR_WIDTH = 5;
   localparam int REG_COUNT      = 32;
   localparam int IMM_WIDTH      = 16;

   typedef logic [WORD_WIDTH-1:0]     word_t;
   typedef logic [BYTE_WIDTH-1:0]     byte_t;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

   // ##################################################
   // Instruction fields
   localparam int OPCODE_MSB = 31;
   localparam int OPCODE_LSB = 26;
   localparam int RS_MSB     = 25;
   localparam int RS_LSB     = 21;
   localparam int RT_MSB     = 20;
   localparam int RT_LSB     = 16;
   localparam int RD_MSB     = 15;
   localparam int RD_LSB     = 11;
   localparam int IMM_MSB    = 15;
   localparam int IMM_LSB    = 0;

   // ##################################################
   // Opcodes
   typedef enum logic [5:0] {
      OP_ADD  = 6'h00,
      OP_SUB  = 6'h01,
      OP_AND  = 6'h02,
      OP_OR   = 6'h03,
      OP_SLT  = 6'h04,
      OP_ADDI = 6'h08,
      OP_LW   = 6'h10,
      OP_SW   = 6'h11,
      OP_BEQ  = 6'h18,
      OP_BNE  = 6'h19,
      OP_JUMP = 6'h1a,
      OP_SEND = 6'h20,
      OP_RECV = 6'h21,
      OP_HALT = 6'h3f
   } opcode_t;

   // Loading stops on this word, it is never stored
   localparam word_t LOAD_END_WORD = '1;

endpackage

`default_nettype wire

// File: design/register_file.sv
// Integer register file, two combinational reads and one write, r0 fixed at zero
`timescale 1ns/1ps
`default_nettype none

module register_file
   import mimic_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  reg_addr_t rs_addr,
   input  reg_addr_t rt_addr,
   output word_t     rs_data,
   output word_t     rt_data,
   input  logic      write_enable,
   input  reg_addr_t write_addr,
   input  word_t     write_data
);

   word_t regs [REG_COUNT];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (write_enable && (write_addr != '0)) begin
         regs[write_addr] <= write_data;
      end
   end

   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: design/sequencer.sv
// Phase FSM, program counter, write-back select and external strobes
`timescale 1ns/1ps
`default_nettype none

module sequencer
   import mimic_pkg::*;
#(
   parameter int IMEM_ADDR_WIDTH = 10
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       in_execution,
   input  opcode_t                    opcode,
   input  reg_addr_t                  rt_addr,
   input  reg_addr_t                  rd_addr,
   input  word_t                      imm,
   input  word_t                      alu_result,
   input  word_t                      rt_data,
   input  word_t                      mem_read_data,
   input  logic                       branch_taken,
   input  logic                       rx_waiting,
   input  byte_t                      rx_received_data,
   output logic [IMEM_ADDR_WIDTH-1:0] pc,
   output logic                       decode_load,
   output logic                       reg_write_enable,
   output reg_addr_t                  reg_write_addr,
   output word_t                      reg_write_data,
   output logic                       mem_write_enable,
   output word_t                      mem_addr,
   output word_t                      mem_write_data,
   output logic                       tx_send_enable,
   output byte_t                      tx_send_data,
   output logic                       rx_pop,
   output logic                       halted
);

   typedef enum logic [2:0] {
      PH_IDLE,
      PH_FETCH,
      PH_DECODE,
      PH_EXECUTE,
      PH_WRITEBACK,
      PH_HALT
   } phase_t;

   phase_t                     phase;
   phase_t                     phase_next;
   logic [IMEM_ADDR_WIDTH-1:0] pc_plus_one;
   logic                       rtype;
   byte_t                      rx_byte;

   // ##################################################
   // Phase machine
   always_comb begin
      phase_next = phase;
      case (phase)
         PH_IDLE:      if (in_execution) phase_next = PH_FETCH;
         PH_FETCH:     phase_next = PH_DECODE;
         PH_DECODE:    phase_next = PH_EXECUTE;
         PH_EXECUTE: begin
            if (opcode == OP_HALT) begin
               phase_next = PH_HALT;
            end else if (opcode != OP_RECV || !rx_waiting) begin
               phase_next = PH_WRITEBACK;
            end
         end
         PH_WRITEBACK: phase_next = PH_FETCH;
         default:      phase_next = PH_HALT;
      endcase
   end

   assign pc_plus_one = pc + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase <= PH_IDLE;
         pc    <= '0;
      end else begin
         phase <= phase_next;
         if (phase == PH_WRITEBACK) begin
            if (opcode == OP_JUMP) begin
               pc <= imm[IMEM_ADDR_WIDTH-1:0];
            end else if (branch_taken) begin
               pc <= pc_plus_one + imm[IMEM_ADDR_WIDTH-1:0];
            end else begin
               pc <= pc_plus_one;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_pop) begin
         rx_byte <= rx_received_data;
      end
   end

   assign decode_load = (phase == PH_DECODE);
   assign halted      = (phase == PH_HALT);

   // ##################################################
   // External strobes
   assign mem_write_enable = (phase == PH_EXECUTE) && (opcode == OP_SW);
   assign mem_addr         = alu_result;
   assign mem_write_data   = rt_data;
   assign tx_send_enable   = (phase == PH_EXECUTE) && (opcode == OP_SEND);
   assign tx_send_data     = rt_data[BYTE_WIDTH-1:0];
   assign rx_pop           = (phase == PH_EXECUTE) && (opcode == OP_RECV) && !rx_waiting;

   // ##################################################
   // Write-back
   assign rtype = (opcode == OP_ADD) || (opcode == OP_SUB) || (opcode == OP_AND) ||
                  (opcode == OP_OR) || (opcode == OP_SLT);

   assign reg_write_enable = (phase == PH_WRITEBACK) &&
                             (rtype || opcode == OP_ADDI || opcode == OP_LW ||
                              opcode == OP_RECV);
   assign reg_write_addr   = rtype ? rd_addr : rt_addr;

   always_comb begin
      case (opcode)
         OP_LW:   reg_write_data = mem_read_data;
         OP_RECV: reg_write_data = {{(WORD_WIDTH-BYTE_WIDTH){1'b0}}, rx_byte};
         default: reg_write_data = alu_result;
      endcase
   end

endmodule

`default_nettype wire

// File: filelist.f
design/mimic_pkg.sv
design/instruction_memory.sv
design/instruction_loader.sv
design/decoder.sv
design/register_file.sv
design/alu.sv
design/sequencer.sv
design/mimic.sv
testbench/mimic_assert.sv
testbench/mimic_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator and run; the exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mimic_tb -f filelist.f -o mimic_tb_sim &&
./obj_dir/mimic_tb_sim || { echo "mimic simulation did not pass"; exit 1; }

// File: testbench/mimic_assert.sv
// Concurrent checks on the mimic FIFO, transmitter and memory strobes
`timescale 1ns/1ps
`default_nettype none

module mimic_assert (
   input logic clk,
   input logic arst_n,
   input logic rx_waiting,
   input logic rx_fifo_pop,
   input logic tx_send_enable,
   input logic mem_write_enable,
   input logic halted
);

   int violation_count = 0;

   assert property (@(posedge clk) disable iff (!arst_n) rx_fifo_pop |-> !rx_waiting)
      else begin
         $error("rx_fifo_pop while rx_waiting is high");
         violation_count++;
      end

   // Send is a single-cycle pulse
   assert property (@(posedge clk) disable iff (!arst_n) tx_send_enable |=> !tx_send_enable)
      else begin
         $error("tx_send_enable held longer than one cycle");
         violation_count++;
      end

   assert property (@(posedge clk) disable iff (!arst_n) !(mem_write_enable && tx_send_enable))
      else begin
         $error("store and send in the same cycle");
         violation_count++;
      end

   assert property (@(posedge clk) disable iff (!arst_n)
                    halted |-> !(tx_send_enable || mem_write_enable || rx_fifo_pop))
      else begin
         $error("strobe raised after halt");
         violation_count++;
      end

endmodule

bind mimic mimic_assert mimic_assert_inst (
   .clk(clk), .arst_n(arst_n), .rx_waiting(rx_waiting), .rx_fifo_pop(rx_fifo_pop),
   .tx_send_enable(tx_send_enable), .mem_write_enable(mem_write_enable), .halted(halted));

`default_nettype wire

// File: testbench/mimic_tb.sv
// Testbench for the mimic core that loads one program per table row and checks tx and memory
`timescale 1ns/1ps
`default_nettype none

module mimic_tb
   import mimic_pkg::*;
();

   typedef struct {
      opcode_t     op;
      byte_t       a;
      byte_t       b;
      logic [15:0] imm;
   } row_t;

   localparam int    ROW_COUNT  = 8;
   localparam int    DMEM_WORDS = 256;
   localparam int    WAIT_LIMIT = 3000;
   localparam byte_t MARK_BYTE  = 8'h5a;

   logic  clk = 1'b0;
   logic  arst_n;
   logic  mem_write_enable;
   word_t mem_addr;
   word_t mem_write_data;
   word_t mem_read_data;
   logic  tx_send_enable;
   byte_t tx_send_data;
   byte_t rx_received_data;
   logic  rx_waiting;
   logic  rx_fifo_pop;
   logic  halted;

   row_t       rows [ROW_COUNT];
   word_t      dmem [DMEM_WORDS];
   logic [7:0] read_index = '0;
   byte_t      rx_queue[$];
   byte_t      tx_expected[$];
   word_t      store_addr_expected[$];
   word_t      store_data_expected[$];
   word_t      program_words[$];
   logic       pop_taken = 1'b0;
   int         hold_cycles = 0;

   mimic #(.IMEM_ADDR_WIDTH(10)) dut0 (
      .clk(clk), .arst_n(arst_n),
      .mem_write_enable(mem_write_enable), .mem_addr(mem_addr),
      .mem_write_data(mem_write_data), .mem_read_data(mem_read_data),
      .tx_send_enable(tx_send_enable), .tx_send_data(tx_send_data),
      .rx_received_data(rx_received_data), .rx_waiting(rx_waiting),
      .rx_fifo_pop(rx_fifo_pop), .halted(halted));

   always #50 clk = ~clk;

   // ##################################################
   // Checks
   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("[ERROR] %s: expected 0x%02h, got 0x%02h",
                                     name, expected, actual));
      end
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("[ERROR] %s: expected 0x%08h, got 0x%08h",
                                     name, expected, actual));
      end
   endtask

   // ##################################################
   // FIFO, data memory and transmitter models
   // Pop seen before the edge's register updates
   always @(posedge clk) begin
      pop_taken <= rx_fifo_pop;
   end

   // Receive FIFO with random empty stretches
   initial begin
      void'($urandom(2907));
      rx_waiting       = 1'b1;
      rx_received_data = '0;
      forever begin
         @(negedge clk);
         if (pop_taken) begin
            if (rx_queue.size() == 0) begin
               stop_with_failure("the core popped the receive FIFO while it was empty");
            end else begin
               void'(rx_queue.pop_front());
            end
         end
         if (hold_cycles != 0) begin
            hold_cycles = hold_cycles - 1;
            rx_waiting <= 1'b1;
         end else if (rx_queue.size() == 0) begin
            rx_waiting <= 1'b1;
         end else begin
            rx_waiting       <= 1'b0;
            rx_received_data <= rx_queue[0];
            if ($urandom_range(7, 0) == 0) begin
               hold_cycles = $urandom_range(3, 1);
            end
         end
      end
   end

   // Read data follows its address by one cycle
   always @(negedge clk) begin
      mem_read_data <= dmem[read_index];
      read_index    <= mem_addr[7:0];
      if (mem_write_enable) begin
         if (store_addr_expected.size() == 0) begin
            stop_with_failure("the core stored to data memory more often than the program does");
         end else begin
            check_word("mem_addr", store_addr_expected.pop_front(), mem_addr);
            check_word("mem_write_data", store_data_expected.pop_front(), mem_write_data);
            dmem[mem_addr[7:0]] <= mem_write_data;
         end
      end
   end

   always @(negedge clk) begin
      if (dut0.mimic_assert_inst.violation_count != 0) begin
         stop_with_failure("a bound assertion on the core strobes failed");
      end
      if (tx_send_enable) begin
         if (tx_expected.size() == 0) begin
            stop_with_failure("the core sent a byte that the program does not send");
         end else begin
            check_byte("tx_send_data", tx_expected.pop_front(), tx_send_data);
         end
      end
   end

   // ##################################################
   // Program building
   function automatic word_t pack_instruction(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                              logic [15:0] low);
      return {op, rs, rt, low};
   endfunction

   function automatic word_t expected_result(opcode_t op, word_t x, word_t y, word_t imm_ext);
      case (op)
         OP_ADD:  return x + y;
         OP_SUB:  return x - y;
         OP_AND:  return x & y;
         OP_OR:   return x | y;
         OP_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         OP_ADDI: return x + imm_ext;
         default: return '0;
      endcase
   endfunction

   task automatic build_program(input row_t r);
      program_words = {};
      program_words.push_back(pack_instruction(OP_RECV, 5'd0, 5'd1, 16'd0));
      program_words.push_back(pack_instruction(OP_RECV, 5'd0, 5'd2, 16'd0));
      program_words.push_back(pack_instruction(OP_ADDI, 5'd2, 5'd2, r.imm));
      if (r.op == OP_ADDI) begin
         program_words.push_back(pack_instruction(OP_ADDI, 5'd1, 5'd3, r.imm));
      end else begin
         program_words.push_back(pack_instruction(r.op, 5'd1, 5'd2, {5'd3, 11'd0}));
      end
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd3, 16'd0));
      program_words.push_back(pack_instruction(OP_SW, 5'd0, 5'd3, 16'd16));
      program_words.push_back(pack_instruction(OP_LW, 5'd0, 5'd4, 16'd16));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd4, 16'd0));
      program_words.push_back(pack_instruction(OP_SW, 5'd0, 5'd4, 16'd20));
      program_words.push_back(pack_instruction(OP_ADDI, 5'd0, 5'd5, {8'd0, MARK_BYTE}));
      // Taken branches skip the marker send that follows them
      program_words.push_back(pack_instruction(OP_BEQ, 5'd3, 5'd4, 16'd1));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd5, 16'd0));
      program_words.push_back(pack_instruction(OP_BNE, 5'd3, 5'd4, 16'd1));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd5, 16'd0));
      program_words.push_back(pack_instruction(OP_BNE, 5'd5, 5'd0, 16'd1));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd5, 16'd0));
      program_words.push_back(pack_instruction(OP_BEQ, 5'd5, 5'd0, 16'd1));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd5, 16'd0));
      program_words.push_back(pack_instruction(OP_JUMP, 5'd0, 5'd0, 16'd20));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd5, 16'd0));
      program_words.push_back(pack_instruction(OP_ADDI, 5'd5, 5'd0, 16'd7));
      program_words.push_back(pack_instruction(OP_SEND, 5'd0, 5'd0, 16'd0));
      program_words.push_back(pack_instruction(OP_HALT, 5'd0, 5'd0, 16'd0));
   endtask

   // Most significant byte goes out first
   task automatic stream_word(input word_t w);
      rx_queue.push_back(w[31:24]);
      rx_queue.push_back(w[23:16]);
      rx_queue.push_back(w[15:8]);
      rx_queue.push_back(w[7:0]);
   endtask

   // ##################################################
   // Sequencing
   task automatic apply_reset;
      @(negedge clk);
      arst_n <= 1'b0;
      repeat (10) @(negedge clk);
      arst_n <= 1'b1;
   endtask

   task automatic wait_fifo_empty;
      int cycles = 0;
      while (rx_queue.size() != 0) begin
         if (cycles == WAIT_LIMIT) begin
            stop_with_failure("timeout while the loader drained the program bytes");
         end
         @(posedge clk);
         cycles++;
      end
   endtask

   task automatic wait_halted;
      int cycles = 0;
      while (!halted) begin
         if (cycles == WAIT_LIMIT) begin
            stop_with_failure("timeout while waiting for the core to halt");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic run_row(input row_t r);
      word_t imm_ext;
      word_t result;
      imm_ext = {{16{r.imm[15]}}, r.imm};
      result  = expected_result(r.op, {24'd0, r.a}, {24'd0, r.b} + imm_ext, imm_ext);
      apply_reset();
      @(posedge clk);
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = 32'h6d000000 ^ (i * 32'h00010101);
      end
      tx_expected         = '{result[7:0], result[7:0], MARK_BYTE, MARK_BYTE, 8'h00};
      store_addr_expected = '{32'd16, 32'd20};
      store_data_expected = '{result, result};
      build_program(r);
      foreach (program_words[i]) begin
         stream_word(program_words[i]);
      end
      stream_word(LOAD_END_WORD);
      wait_fifo_empty();
      // First RECV has to sit on the empty FIFO
      repeat (20) @(negedge clk) begin
         if (halted) begin
            stop_with_failure("the core halted before its operands arrived");
         end
      end
      @(posedge clk);
      rx_queue.push_back(r.a);
      rx_queue.push_back(r.b);
      wait_halted();
      @(posedge clk);
      if (rx_queue.size() != 0 || tx_expected.size() != 0 || store_addr_expected.size() != 0) begin
         stop_with_failure("the core halted with operand bytes, sends or stores still pending");
      end
      repeat (50) @(negedge clk) begin
         if (!halted || tx_send_enable || mem_write_enable || pop_taken) begin
            stop_with_failure("the core left halt or raised a strobe after halting");
         end
      end
   endtask

   initial begin
      arst_n        = 1'b0;
      mem_read_data = '0;
      rows[0] = '{OP_ADD,  8'h12, 8'h34, 16'h0100};
      rows[1] = '{OP_SUB,  8'h05, 8'h09, 16'h0000};
      rows[2] = '{OP_AND,  8'hf0, 8'h3c, 16'hff00};
      rows[3] = '{OP_OR,   8'h81, 8'h18, 16'h0200};
      rows[4] = '{OP_SLT,  8'h10, 8'h20, 16'h0000};
      rows[5] = '{OP_SLT,  8'h10, 8'h20, 16'hff00};
      rows[6] = '{OP_ADDI, 8'h40, 8'h01, 16'hfff0};
      rows[7] = '{OP_ADD,  8'h00, 8'hff, 16'h7fff};
      for (int i = 0; i < ROW_COUNT; i++) begin
         run_row(rows[i]);
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
